// File: files.f
+incdir+hw
hw/gfx_pkg.sv
hw/gfx_wb_slave.sv
hw/gfx_cmd_fifo.sv
hw/gfx_reg_file.sv
hw/gfx_pipe_ctrl.sv
hw/gfx_top.sv
test/tb_gfx_top.sv

// File: test/tb_gfx_top.sv
// directed testbench for the graphics register front end
// drives bus accesses and the pipeline handshake, checks readback and outputs
// stops at the first mismatch, a watchdog bounds the run
`timescale 1ns/100ps
`include "gfx_params.svh"

module tb_gfx_top;

  localparam int DRIVE_DELAY = 10;
  localparam int RESP_LIMIT  = 50;
  localparam int FIFO_DEPTH  = 1 << `GFX_FIFO_DEPTH_LOG2;
  // each test needs a few hundred cycles at most, this leaves a wide margin
  localparam int WATCHDOG_CYCLES = 20000;

  logic clk_i;
  logic rst_i;
  gfx_pkg::reg_adr_t     adr_i;
  gfx_pkg::reg_word_t    dat_i;
  gfx_pkg::reg_word_t    dat_o;
  logic [3:0]            sel_i;
  logic                  we_i;
  logic                  stb_i;
  logic                  cyc_i;
  logic                  ack_o;
  logic                  err_o;
  logic                  inta_o;
  logic                  writer_sint_i;
  logic                  reader_sint_i;
  logic                  pipeline_ack_i;
  gfx_pkg::base_adr_t    target_base_o;
  gfx_pkg::point_t       target_size_x_o;
  gfx_pkg::point_t       target_size_y_o;
  gfx_pkg::fixed_t       dest_pixel_x_o;
  gfx_pkg::fixed_t       dest_pixel_y_o;
  gfx_pkg::reg_word_t    color0_o;
  gfx_pkg::color_depth_t color_depth_o;
  logic                  rect_write_o;
  logic                  line_write_o;

  logic [31:0] lfsr_q;
  logic [31:0] color0_expect;
  int          rect_pulses;
  int          line_pulses;
  int unsigned reg_offsets [8] = '{`GFX_REG_CONTROL, `GFX_REG_STATUS, `GFX_REG_TARGET_BASE,
    `GFX_REG_TARGET_SIZE_X, `GFX_REG_TARGET_SIZE_Y, `GFX_REG_DEST_X, `GFX_REG_DEST_Y,
    `GFX_REG_COLOR0};

  gfx_top dut0 (.*);

  always #50 clk_i = ~clk_i;

  // trigger outputs are sampled on the edge that would consume them
  always @(posedge clk_i)
  begin
    if (rect_write_o)
      rect_pulses++;
    if (line_write_o)
      line_pulses++;
  end

  initial
  begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
    $display("TEST FAIL");
    $fatal(1);
  end

  // Fibonacci LFSR with taps 32 22 2 1, one step per bit taken
  function automatic logic [31:0] lfsr_word();
    logic [31:0] w;
    logic        fb;
    w = '0;
    for (int i = 0; i < 32; i++)
    begin
      fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      w = {w[30:0], fb};
    end
    return w;
  endfunction

  // expected status word, busy flag plus pending count
  function automatic logic [31:0] status_of(input logic busy, input int count);
    logic [31:0] w;
    w = '0;
    w[`GFX_STAT_BUSY] = busy;
    w[`GFX_STAT_COUNT_LSB +: 8] = count[7:0];
    return w;
  endfunction

  task automatic check_eq(input logic [31:0] actual, input logic [31:0] expected,
                          input string what);
    if (actual !== expected)
    begin
      $display("[ERROR] %0t ns %s: got 0x%08h, expected 0x%08h", $time, what, actual, expected);
      $display("TEST FAIL");
      $fatal(1);
    end
  endtask

  task automatic bus_start(input logic [31:0] adr, input logic [31:0] data,
                           input logic [3:0] sel, input logic we);
    adr_i = adr[`GFX_ADR_W-1:0];
    dat_i = data;
    sel_i = sel;
    we_i  = we;
    cyc_i = 1'b1;
    stb_i = 1'b1;
  endtask

  // ends the cycle on ack or err, then leaves one idle cycle
  task automatic bus_wait(input int max_cycles, output logic got_ack, output logic got_err,
                          output logic [31:0] rdata);
    int n;
    got_ack = 1'b0;
    got_err = 1'b0;
    rdata   = '0;
    n = 0;
    while (!got_ack && !got_err && n < max_cycles)
    begin
      @(posedge clk_i);
      #DRIVE_DELAY;
      got_ack = ack_o;
      got_err = err_o;
      rdata   = dat_o;
      n++;
    end
    if (got_ack || got_err)
    begin
      cyc_i = 1'b0;
      stb_i = 1'b0;
      we_i  = 1'b0;
      @(posedge clk_i);
      #DRIVE_DELAY;
    end
  endtask

  task automatic require_response(input logic got, input logic [31:0] adr);
    if (!got)
    begin
      $display("bus access to offset 0x%0h got neither ack nor err", adr);
      $display("TEST FAIL");
      $fatal(1);
    end
  endtask

  task automatic wb_write(input logic [31:0] adr, input logic [31:0] data);
    logic a;
    logic e;
    logic [31:0] rd;
    bus_start(adr, data, 4'hf, 1'b1);
    bus_wait(RESP_LIMIT, a, e, rd);
    require_response(a | e, adr);
    check_eq(a, 1'b1, "write ack");
  endtask

  task automatic wb_read(input logic [31:0] adr, output logic [31:0] data);
    logic a;
    logic e;
    bus_start(adr, 32'h0, 4'hf, 1'b0);
    bus_wait(RESP_LIMIT, a, e, data);
    require_response(a | e, adr);
    check_eq(a, 1'b1, "read ack");
  endtask

  // polls status until it shows the expected value or gives up
  task automatic wait_status(input logic [31:0] expected);
    logic [31:0] rd;
    int tries;
    tries = 0;
    wb_read(`GFX_REG_STATUS, rd);
    while (rd !== expected && tries < 100)
    begin
      wb_read(`GFX_REG_STATUS, rd);
      tries++;
    end
    check_eq(rd, expected, "status while waiting");
  endtask

  task automatic pulse_pipeline_ack();
    pipeline_ack_i = 1'b1;
    @(posedge clk_i);
    #DRIVE_DELAY;
    pipeline_ack_i = 1'b0;
  endtask

  task automatic test_reset();
    logic [31:0] rd;
    foreach (reg_offsets[i])
    begin
      wb_read(reg_offsets[i], rd);
      check_eq(rd, 32'h0, $sformatf("reset value of offset 0x%0h", reg_offsets[i]));
    end
  endtask

  task automatic test_write_readback();
    logic [31:0] sx;
    logic [31:0] sy;
    logic [31:0] dx;
    logic [31:0] dy;
    logic [31:0] rd;
    sx = lfsr_word();
    sy = lfsr_word();
    dx = lfsr_word();
    dy = lfsr_word();
    color0_expect = lfsr_word();
    wb_write(`GFX_REG_TARGET_SIZE_X, sx);
    wb_write(`GFX_REG_TARGET_SIZE_Y, sy);
    wb_write(`GFX_REG_DEST_X, dx);
    wb_write(`GFX_REG_DEST_Y, dy);
    wb_write(`GFX_REG_COLOR0, color0_expect);
    wait_status(status_of(1'b0, 0));
    wb_read(`GFX_REG_TARGET_SIZE_X, rd);
    check_eq(rd, sx, "target size x readback");
    wb_read(`GFX_REG_TARGET_SIZE_Y, rd);
    check_eq(rd, sy, "target size y readback");
    wb_read(`GFX_REG_DEST_X, rd);
    check_eq(rd, dx, "dest x readback");
    wb_read(`GFX_REG_DEST_Y, rd);
    check_eq(rd, dy, "dest y readback");
    wb_read(`GFX_REG_COLOR0, rd);
    check_eq(rd, color0_expect, "color0 readback");
    check_eq(target_size_x_o, sx[`GFX_POINT_W-1:0], "target_size_x_o");
    check_eq(target_size_y_o, sy[`GFX_POINT_W-1:0], "target_size_y_o");
    check_eq(dest_pixel_x_o, dx, "dest_pixel_x_o");
    check_eq(dest_pixel_y_o, dy, "dest_pixel_y_o");
    check_eq(color0_o, color0_expect, "color0_o");
  endtask

  task automatic test_bad_access();
    logic a;
    logic e;
    logic [31:0] rd;
    bus_start(`GFX_REG_TARGET_BASE, lfsr_word(), 4'b0011, 1'b1);
    bus_wait(RESP_LIMIT, a, e, rd);
    check_eq(e, 1'b1, "err on partial write");
    check_eq(a, 1'b0, "no ack on partial write");
    wait_status(status_of(1'b0, 0));
    wb_read(`GFX_REG_TARGET_BASE, rd);
    check_eq(rd, 32'h0, "target base after partial write");
    check_eq(target_base_o, 30'h0, "target_base_o after partial write");
  endtask

  task automatic test_rect();
    logic [31:0] ctrl;
    logic [31:0] v;
    logic [31:0] rd;
    int pulses_before;
    int line_before;
    ctrl = '0;
    ctrl[`GFX_CTRL_RECT] = 1'b1;
    ctrl[`GFX_CTRL_COLOR_DEPTH +: 2] = 2'b10;
    pulses_before = rect_pulses;
    line_before = line_pulses;
    wb_write(`GFX_REG_CONTROL, ctrl);
    wait_status(status_of(1'b1, 0));
    check_eq(rect_pulses - pulses_before, 1, "rect trigger pulses");
    check_eq(line_pulses - line_before, 0, "no line pulse on rect trigger");
    check_eq(color_depth_o, 2'b10, "color_depth_o");
    v = lfsr_word();
    wb_write(`GFX_REG_COLOR0, v);
    repeat (10) @(posedge clk_i);
    #DRIVE_DELAY;
    wb_read(`GFX_REG_STATUS, rd);
    check_eq(rd, status_of(1'b1, 1), "status with one queued write");
    check_eq(color0_o, color0_expect, "color0_o held while busy");
    pulse_pipeline_ack();
    wait_status(status_of(1'b0, 0));
    color0_expect = v;
    check_eq(color0_o, v, "color0_o after pipeline ack");
    ctrl[`GFX_CTRL_RECT] = 1'b0;
    wb_read(`GFX_REG_CONTROL, rd);
    check_eq(rd, ctrl, "control after trigger cleared");
    check_eq(rect_pulses - pulses_before, 1, "rect trigger pulses after ack");
  endtask

  // the line trigger keeps the core busy while the FIFO fills up
  task automatic test_full_fifo();
    logic [31:0] ctrl;
    logic [31:0] last;
    logic [31:0] rd;
    logic a;
    logic e;
    int rect_before;
    int line_before;
    ctrl = '0;
    ctrl[`GFX_CTRL_LINE] = 1'b1;
    rect_before = rect_pulses;
    line_before = line_pulses;
    wb_write(`GFX_REG_CONTROL, ctrl);
    wait_status(status_of(1'b1, 0));
    check_eq(line_pulses - line_before, 1, "line trigger pulses");
    check_eq(rect_pulses - rect_before, 0, "no rect pulse on line trigger");
    for (int i = 0; i < FIFO_DEPTH; i++)
      wb_write(`GFX_REG_COLOR0, lfsr_word());
    wb_read(`GFX_REG_STATUS, rd);
    check_eq(rd, status_of(1'b1, FIFO_DEPTH), "status with full FIFO");
    last = lfsr_word();
    bus_start(`GFX_REG_COLOR0, last, 4'hf, 1'b1);
    bus_wait(20, a, e, rd);
    check_eq(a | e, 1'b0, "response to write while FIFO full");
    pulse_pipeline_ack();
    bus_wait(RESP_LIMIT, a, e, rd);
    check_eq(a, 1'b1, "held write acked after drain starts");
    wait_status(status_of(1'b0, 0));
    wb_read(`GFX_REG_COLOR0, rd);
    check_eq(rd, last, "color0 after full FIFO drained");
    check_eq(color0_o, last, "color0_o after full FIFO drained");
    check_eq(line_pulses - line_before, 1, "line trigger pulses after ack");
  endtask

  task automatic test_interrupt();
    check_eq(inta_o, 1'b0, "inta_o idle");
    writer_sint_i = 1'b1;
    @(posedge clk_i);
    #DRIVE_DELAY;
    check_eq(inta_o, 1'b1, "inta_o from writer");
    writer_sint_i = 1'b0;
    reader_sint_i = 1'b1;
    @(posedge clk_i);
    #DRIVE_DELAY;
    check_eq(inta_o, 1'b1, "inta_o from reader");
    reader_sint_i = 1'b0;
    @(posedge clk_i);
    #DRIVE_DELAY;
    check_eq(inta_o, 1'b0, "inta_o released");
  endtask

  initial
  begin
    clk_i = 1'b0;
    rst_i = 1'b1;
    adr_i = '0;
    dat_i = '0;
    sel_i = '0;
    we_i  = 1'b0;
    stb_i = 1'b0;
    cyc_i = 1'b0;
    writer_sint_i  = 1'b0;
    reader_sint_i  = 1'b0;
    pipeline_ack_i = 1'b0;
    rect_pulses = 0;
    line_pulses = 0;
    lfsr_q = 32'h45f2;
    repeat (10) @(posedge clk_i);
    #DRIVE_DELAY;
    rst_i = 1'b0;
    @(posedge clk_i);
    #DRIVE_DELAY;
    test_reset();
    test_write_readback();
    test_bad_access();
    test_rect();
    test_full_fifo();
    test_interrupt();
    $display("TEST PASS");
    $finish;
  end

endmodule

// File: hw/gfx_top.sv
// register front end of the 2D graphics accelerator
// bus writes go through the command FIFO to the register file, which drives
// the drawing pipeline; reads return the register contents directly
`timescale 1ns/100ps
`include "gfx_params.svh"

module gfx_top (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  gfx_pkg::reg_adr_t     adr_i,
  input  gfx_pkg::reg_word_t    dat_i,
  output gfx_pkg::reg_word_t    dat_o,
  input  logic [3:0]            sel_i,
  input  logic                  we_i,
  input  logic                  stb_i,
  input  logic                  cyc_i,
  output logic                  ack_o,
  output logic                  err_o,
  output logic                  inta_o,
  input  logic                  writer_sint_i,
  input  logic                  reader_sint_i,
  input  logic                  pipeline_ack_i,
  output gfx_pkg::base_adr_t    target_base_o,
  output gfx_pkg::point_t       target_size_x_o,
  output gfx_pkg::point_t       target_size_y_o,
  output gfx_pkg::fixed_t       dest_pixel_x_o,
  output gfx_pkg::fixed_t       dest_pixel_y_o,
  output gfx_pkg::reg_word_t    color0_o,
  output gfx_pkg::color_depth_t color_depth_o,
  output logic                  rect_write_o,
  output logic                  line_write_o
);

  // FIFO entry is address on top of data
  localparam int CMD_W = `GFX_ADR_W + 32;

  logic                 enq;
  gfx_pkg::reg_adr_t    enq_adr;
  logic                 fifo_full;
  logic                 fifo_valid;
  gfx_pkg::fifo_count_t fifo_count;
  gfx_pkg::reg_adr_t    head_adr;
  gfx_pkg::reg_word_t   head_data;
  logic                 deq;
  logic                 busy;

  gfx_wb_slave wbs0 (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .adr_i         (adr_i),
    .sel_i         (sel_i),
    .we_i          (we_i),
    .stb_i         (stb_i),
    .cyc_i         (cyc_i),
    .fifo_full_i   (fifo_full),
    .writer_sint_i (writer_sint_i),
    .reader_sint_i (reader_sint_i),
    .ack_o         (ack_o),
    .err_o         (err_o),
    .inta_o        (inta_o),
    .enq_o         (enq),
    .enq_adr_o     (enq_adr)
  );

  gfx_cmd_fifo #(
    .DATA_W     (CMD_W),
    .DEPTH_LOG2 (`GFX_FIFO_DEPTH_LOG2)
  ) fifo0 (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .enq_i   (enq),
    .data_i  ({enq_adr, dat_i}),
    .deq_i   (deq),
    .data_o  ({head_adr, head_data}),
    .valid_o (fifo_valid),
    .full_o  (fifo_full),
    .count_o (fifo_count)
  );

  gfx_reg_file regs0 (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .deq_i           (deq),
    .cmd_adr_i       (head_adr),
    .cmd_data_i      (head_data),
    .rd_adr_i        (adr_i),
    .busy_i          (busy),
    .fifo_count_i    (fifo_count),
    .rd_data_o       (dat_o),
    .target_base_o   (target_base_o),
    .target_size_x_o (target_size_x_o),
    .target_size_y_o (target_size_y_o),
    .dest_pixel_x_o  (dest_pixel_x_o),
    .dest_pixel_y_o  (dest_pixel_y_o),
    .color0_o        (color0_o),
    .color_depth_o   (color_depth_o),
    .rect_write_o    (rect_write_o),
    .line_write_o    (line_write_o)
  );

  gfx_pipe_ctrl ctrl0 (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .fifo_valid_i   (fifo_valid),
    .rect_write_i   (rect_write_o),
    .line_write_i   (line_write_o),
    .pipeline_ack_i (pipeline_ack_i),
    .deq_o          (deq),
    .busy_o         (busy)
  );

endmodule

// File: hw/gfx_pipe_ctrl.sv
// pipeline handshake and FIFO drain gate
// a trigger puts the core in busy until the pipeline acks
// commands are popped at most every other cycle and only while waiting
`timescale 1ns/100ps

module gfx_pipe_ctrl (
  input  logic clk_i,
  input  logic rst_i,
  input  logic fifo_valid_i,
  input  logic rect_write_i,
  input  logic line_write_i,
  input  logic pipeline_ack_i,
  output logic deq_o,
  output logic busy_o
);

  gfx_pkg::gfx_state_e state_q;
  logic                deq_prev_q;
  logic                trigger;

  assign trigger = rect_write_i | line_write_i;

  // the gap after a pop gives the register file a cycle to clear triggers
  assign deq_o = fifo_valid_i & (state_q == gfx_pkg::ST_WAIT) & ~trigger & ~deq_prev_q;

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
      deq_prev_q <= 1'b0;
    else
      deq_prev_q <= deq_o;
  end

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
      state_q <= gfx_pkg::ST_WAIT;
    else
    begin
      case (state_q)
        gfx_pkg::ST_WAIT:
        begin
          if (trigger)
            state_q <= gfx_pkg::ST_BUSY;
        end
        gfx_pkg::ST_BUSY:
        begin
          // operation finished
          if (pipeline_ack_i)
            state_q <= gfx_pkg::ST_WAIT;
        end
        default: state_q <= gfx_pkg::ST_WAIT;
      endcase
    end
  end

  assign busy_o = (state_q == gfx_pkg::ST_BUSY);

endmodule

// File: hw/gfx_reg_file.sv
// register storage of the graphics core
// commands popped from the FIFO update one register each, in queue order
// rect/line bits of control act as one cycle triggers for the pipeline
// readback is registered, so rd_data_o follows rd_adr_i one cycle later
`timescale 1ns/100ps
`include "gfx_params.svh"

module gfx_reg_file (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  deq_i,
  input  gfx_pkg::reg_adr_t     cmd_adr_i,
  input  gfx_pkg::reg_word_t    cmd_data_i,
  input  gfx_pkg::reg_adr_t     rd_adr_i,
  input  logic                  busy_i,
  input  gfx_pkg::fifo_count_t  fifo_count_i,
  output gfx_pkg::reg_word_t    rd_data_o,
  output gfx_pkg::base_adr_t    target_base_o,
  output gfx_pkg::point_t       target_size_x_o,
  output gfx_pkg::point_t       target_size_y_o,
  output gfx_pkg::fixed_t       dest_pixel_x_o,
  output gfx_pkg::fixed_t       dest_pixel_y_o,
  output gfx_pkg::reg_word_t    color0_o,
  output gfx_pkg::color_depth_t color_depth_o,
  output logic                  rect_write_o,
  output logic                  line_write_o
);

  gfx_pkg::reg_word_t control_q;
  gfx_pkg::reg_word_t target_base_q;
  gfx_pkg::reg_word_t target_size_x_q;
  gfx_pkg::reg_word_t target_size_y_q;
  gfx_pkg::fixed_t    dest_x_q;
  gfx_pkg::fixed_t    dest_y_q;
  gfx_pkg::reg_word_t color0_q;
  gfx_pkg::reg_word_t status_word;
  gfx_pkg::reg_adr_t  rd_word_adr;

  // write decode, one register per popped command
  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      control_q       <= '0;
      target_base_q   <= '0;
      target_size_x_q <= '0;
      target_size_y_q <= '0;
      dest_x_q        <= '0;
      dest_y_q        <= '0;
      color0_q        <= '0;
    end
    else if (deq_i)
    begin
      case (cmd_adr_i)
        `GFX_REG_CONTROL:       control_q       <= cmd_data_i;
        `GFX_REG_TARGET_BASE:   target_base_q   <= cmd_data_i;
        `GFX_REG_TARGET_SIZE_X: target_size_x_q <= cmd_data_i;
        `GFX_REG_TARGET_SIZE_Y: target_size_y_q <= cmd_data_i;
        `GFX_REG_DEST_X:        dest_x_q        <= gfx_pkg::fixed_t'(cmd_data_i);
        `GFX_REG_DEST_Y:        dest_y_q        <= gfx_pkg::fixed_t'(cmd_data_i);
        `GFX_REG_COLOR0:        color0_q        <= cmd_data_i;
        // status and unmapped offsets are ignored
        default: ;
      endcase
    end
    else
    begin
      // triggers last a single cycle, the drain gate keeps deq low right after a pop
      control_q[`GFX_CTRL_RECT] <= 1'b0;
      control_q[`GFX_CTRL_LINE] <= 1'b0;
    end
  end

  // busy flag plus pending command count
  always_comb
  begin
    status_word = '0;
    status_word[`GFX_STAT_BUSY] = busy_i;
    status_word[`GFX_STAT_COUNT_LSB +: $bits(gfx_pkg::fifo_count_t)] = fifo_count_i;
  end

  assign rd_word_adr = {rd_adr_i[$bits(gfx_pkg::reg_adr_t)-1:2], 2'b00};

  // readback mux, pending FIFO writes are not visible here
  always_ff @(posedge clk_i)
  begin
    case (rd_word_adr)
      `GFX_REG_CONTROL:       rd_data_o <= control_q;
      `GFX_REG_STATUS:        rd_data_o <= status_word;
      `GFX_REG_TARGET_BASE:   rd_data_o <= target_base_q;
      `GFX_REG_TARGET_SIZE_X: rd_data_o <= target_size_x_q;
      `GFX_REG_TARGET_SIZE_Y: rd_data_o <= target_size_y_q;
      `GFX_REG_DEST_X:        rd_data_o <= gfx_pkg::reg_word_t'(dest_x_q);
      `GFX_REG_DEST_Y:        rd_data_o <= gfx_pkg::reg_word_t'(dest_y_q);
      `GFX_REG_COLOR0:        rd_data_o <= color0_q;
      default:                rd_data_o <= '0;
    endcase
  end

  assign target_base_o   = target_base_q[31:2];
  assign target_size_x_o = target_size_x_q[$bits(gfx_pkg::point_t)-1:0];
  assign target_size_y_o = target_size_y_q[$bits(gfx_pkg::point_t)-1:0];
  assign dest_pixel_x_o  = dest_x_q;
  assign dest_pixel_y_o  = dest_y_q;
  assign color0_o        = color0_q;
  assign color_depth_o   = control_q[`GFX_CTRL_COLOR_DEPTH +: 2];
  assign rect_write_o    = control_q[`GFX_CTRL_RECT];
  assign line_write_o    = control_q[`GFX_CTRL_LINE];

  // a combined trigger may appear once but must be cleared on the next edge,
  // which relies on the pipe controller never popping two cycles in a row
  a_trig_one_cycle: assert property (
    @(posedge clk_i) disable iff (rst_i)
    (rect_write_o && line_write_o) |=> !(rect_write_o && line_write_o)
  );

endmodule

// File: hw/gfx_cmd_fifo.sv
// circular command queue between the bus slave and the register file
// head entry is visible on data_o while valid_o is high, deq_i pops it
// DATA_W sets the entry width and DEPTH_LOG2 the number of entries
`timescale 1ns/100ps

module gfx_cmd_fifo #(
  parameter int DATA_W     = 42,
  parameter int DEPTH_LOG2 = 4
) (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 enq_i,
  input  logic [DATA_W-1:0]    data_i,
  input  logic                 deq_i,
  output logic [DATA_W-1:0]    data_o,
  output logic                 valid_o,
  output logic                 full_o,
  output gfx_pkg::fifo_count_t count_o
);

  localparam int DEPTH = 1 << DEPTH_LOG2;

  logic [DATA_W-1:0]     mem [DEPTH];
  logic [DEPTH_LOG2-1:0] wr_ptr_q;
  logic [DEPTH_LOG2-1:0] rd_ptr_q;
  gfx_pkg::fifo_count_t  count_q;

  // storage, written only at the tail
  always_ff @(posedge clk_i)
  begin
    if (enq_i)
      mem[wr_ptr_q] <= data_i;
  end

  // pointers wrap naturally at the power of two depth
  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end
    else
    begin
      if (enq_i)
        wr_ptr_q <= wr_ptr_q + 1'b1;
      if (deq_i)
        rd_ptr_q <= rd_ptr_q + 1'b1;
      // simultaneous push and pop leaves the count alone
      if (enq_i && !deq_i)
        count_q <= count_q + 1'b1;
      else if (deq_i && !enq_i)
        count_q <= count_q - 1'b1;
    end
  end

  assign data_o  = mem[rd_ptr_q];
  assign valid_o = (count_q != '0);
  assign full_o  = (count_q == gfx_pkg::fifo_count_t'(DEPTH));
  assign count_o = count_q;

  // the slave must hold a write back while full
  a_no_overflow: assert property (
    @(posedge clk_i) disable iff (rst_i) full_o |-> !enq_i
  );

  // the drain gate must look at valid before popping
  a_no_underflow: assert property (
    @(posedge clk_i) disable iff (rst_i) !valid_o |-> !deq_i
  );

endmodule

// File: hw/gfx_wb_slave.sv
// bus side of the register front end
// answers full word accesses with a one cycle ack and anything else with err
// writes are queued in the command FIFO and stall while it is full
`timescale 1ns/100ps

module gfx_wb_slave (
  input  logic              clk_i,
  input  logic              rst_i,
  input  gfx_pkg::reg_adr_t adr_i,
  input  logic [3:0]        sel_i,
  input  logic              we_i,
  input  logic              stb_i,
  input  logic              cyc_i,
  input  logic              fifo_full_i,
  input  logic              writer_sint_i,
  input  logic              reader_sint_i,
  output logic              ack_o,
  output logic              err_o,
  output logic              inta_o,
  output logic              enq_o,
  output gfx_pkg::reg_adr_t enq_adr_o
);

  logic acc;
  logic acc_full;
  logic rd_req;
  logic wr_req;

  assign acc      = cyc_i & stb_i;
  assign acc_full = (sel_i == 4'b1111);

  // ack_o blocks a second response while the master still holds stb
  assign rd_req = acc & acc_full & ~we_i & ~ack_o;
  // write waits here until the FIFO has a free slot
  assign wr_req = acc & acc_full & we_i & ~ack_o & ~fifo_full_i;

  // entry goes in on the same edge that raises ack
  assign enq_o     = wr_req;
  assign enq_adr_o = {adr_i[$bits(gfx_pkg::reg_adr_t)-1:2], 2'b00};

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      ack_o  <= 1'b0;
      err_o  <= 1'b0;
      inta_o <= 1'b0;
    end
    else
    begin
      ack_o  <= rd_req | wr_req;
      // partial width access, no data moves
      err_o  <= acc & ~acc_full & ~err_o;
      inta_o <= writer_sint_i | reader_sint_i;
    end
  end

  // a response lasts one cycle as the master drops stb once it sees it
  a_one_cycle_response: assert property (
    @(posedge clk_i) disable iff (rst_i) (ack_o || err_o) |=> !(ack_o || err_o)
  );

endmodule

// File: hw/gfx_pkg.sv
// shared types of the graphics register front end
// modules refer to these as gfx_pkg::name
`include "gfx_params.svh"

package gfx_pkg;

  // raw bus word and byte address
  typedef logic [31:0]            reg_word_t;
  typedef logic [`GFX_ADR_W-1:0] reg_adr_t;

  // pixel coordinate and signed fixed point position
  typedef logic [`GFX_POINT_W-1:0] point_t;
  typedef logic signed [`GFX_POINT_W+`GFX_SUBPIXEL_W-1:0] fixed_t;

  // word aligned memory base, bits 31:2 of a byte address
  typedef logic [29:0] base_adr_t;

  // one extra bit so a full FIFO can be told from an empty one
  typedef logic [`GFX_FIFO_DEPTH_LOG2:0] fifo_count_t;

  typedef logic [1:0] color_depth_t;

  // pipeline handshake
  typedef enum logic {
    ST_WAIT,
    ST_BUSY
  } gfx_state_e;

endpackage

// File: hw/gfx_params.svh
// register map, field positions and sizing of the graphics register front end
// included by the package, the RTL that decodes registers and the testbench
`ifndef GFX_PARAMS_SVH
`define GFX_PARAMS_SVH

// bus address and pixel widths
`define GFX_ADR_W            10
`define GFX_POINT_W          16
`define GFX_SUBPIXEL_W       16

// command FIFO holds 2**4 entries
`define GFX_FIFO_DEPTH_LOG2  4

// register byte offsets
`define GFX_REG_CONTROL        'h00
`define GFX_REG_STATUS         'h04
`define GFX_REG_TARGET_BASE    'h08
`define GFX_REG_TARGET_SIZE_X  'h0C
`define GFX_REG_TARGET_SIZE_Y  'h10
`define GFX_REG_DEST_X         'h14
`define GFX_REG_DEST_Y         'h18
`define GFX_REG_COLOR0         'h1C

// control fields, color depth occupies bits 1:0
`define GFX_CTRL_COLOR_DEPTH   0
`define GFX_CTRL_RECT          4
`define GFX_CTRL_LINE          5

// status fields
`define GFX_STAT_BUSY          0
`define GFX_STAT_COUNT_LSB     16

`endif
